//--- all.f
+incdir+source
source/input_pkg.sv
source/four_way_filter.sv
source/frame_ctrl.sv
source/joy_mapper.sv
source/paddle_accum.sv
source/input_top.sv
verification/input_checker.sv
verification/input_tb.sv

//--- Makefile
# Verilator build and run for the input conditioner testbench

SOURCES := $(wildcard source/*.sv source/*.svh verification/*.sv)

.PHONY: run clean

run: obj_dir/Vinput_tb
	./obj_dir/Vinput_tb | tee sim.log
	grep -q "TESTS PASSED" sim.log

obj_dir/Vinput_tb: all.f $(SOURCES)
	verilator --binary --timing --assert -f all.f --top-module input_tb -o Vinput_tb

clean:
	rm -rf obj_dir sim.log

//--- verification/input_tb.sv
/*
 * Testbench for the input conditioner
 * Clock, reset, seeded random stimulus, directed pause tests, timeout
 */
`default_nettype none

`include "input_macros.svh"

module input_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CYCLE_LIMIT = 20000;        // Six tests, under 2000 cycles each

    logic                clk, rst, vs, en_4way, autofire_en, rot_control, dip_flip, lock;
    input_pkg::raw_joy_t board_joy1, board_joy2;
    input_pkg::joy_t     key_joy1, key_joy2, game_joy1, game_joy2;
    logic [1:0]          board_coin, board_start, key_coin, key_start;
    logic [1:0]          game_coin, game_start;
    logic                key_service, key_tilt, key_pause, osd_pause, key_reset;
    logic [7:0]          board_paddle, game_paddle;
    logic signed [8:0]   bd_mouse_dx;
    logic                bd_mouse_st, game_service, game_tilt, game_pause, soft_rst;
    logic                map_check;
    int                  cycles = 0;

    input_top dut0 (.*);
    input_checker chk0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic ticks(input int n);
        repeat (n) @(posedge clk);
    endtask

    // New random board, key and paddle values every cycle
    task automatic drive_random(input int n, input logic mouse);
        repeat (n) begin
            @(posedge clk);
            board_joy1   <= 16'($urandom) & ~(16'd1 << `INPUT_PAUSE_BIT);
            board_joy2   <= 16'($urandom) & ~(16'd1 << `INPUT_PAUSE_BIT);
            key_joy1     <= input_pkg::joy_t'($urandom);
            key_joy2     <= input_pkg::joy_t'($urandom);
            board_coin   <= 2'($urandom);
            board_start  <= 2'($urandom);
            key_coin     <= 2'($urandom);
            key_start    <= 2'($urandom);
            key_service  <= 1'($urandom);
            key_tilt     <= 1'($urandom);
            board_paddle <= 8'($urandom);
            bd_mouse_st  <= mouse & 1'($urandom);
            bd_mouse_dx  <= 9'($urandom);
        end
    endtask

    // Rotation acts in the output stage, so words in flight drain first
    task automatic set_mode(input logic rot, input logic flip, input logic en4);
        @(posedge clk);
        map_check   <= 1'b0;
        @(posedge clk);
        rot_control <= rot;
        dip_flip    <= flip;
        en_4way     <= en4;
        ticks(3);
        map_check <= 1'b1;
    endtask

    task automatic clear_inputs();
        @(posedge clk);
        map_check <= 1'b0;
        board_joy1 <= '0;
        board_joy2 <= '0;
        key_joy1 <= '0;
        key_joy2 <= '0;
        {board_coin, board_start, key_coin, key_start} <= '0;
        {key_service, key_tilt} <= '0;
    endtask

    task automatic press_pause();
        @(posedge clk);
        key_pause <= 1'b1;
        @(posedge clk);
        key_pause <= 1'b0;
    endtask

    task automatic press_service();
        @(posedge clk);
        key_service <= 1'b1;
        @(posedge clk);
        key_service <= 1'b0;
    endtask

    task automatic frame();
        @(posedge clk);
        vs <= 1'b1;
        ticks(4);
        vs <= 1'b0;
        ticks(16);
    endtask

    task automatic expect_pause(input logic exp);
        ticks(5);
        @(negedge clk);
        chk0.check_value("game_pause", int'(game_pause), int'(exp));
    endtask

    initial begin
        int cnt;
        int highs;
        {rst, vs, en_4way, autofire_en, rot_control, dip_flip, lock} = 7'b1000000;
        {board_joy1, board_joy2, key_joy1, key_joy2} = '0;
        {board_coin, board_start, key_coin, key_start} = '0;
        {key_service, key_tilt, key_pause, osd_pause, key_reset} = '0;
        board_paddle = '0;
        bd_mouse_dx = '0;
        bd_mouse_st = 1'b0;
        map_check = 1'b0;
        void'($urandom(60));
        ticks(10);
        rst <= 1'b0;

        set_mode(1'b0, 1'b0, 1'b0);
        drive_random(200, 1'b0);
        chk0.finish_test("merge and polarity");

        set_mode(1'b1, 1'b0, 1'b0);
        drive_random(200, 1'b0);
        set_mode(1'b1, 1'b1, 1'b0);
        drive_random(200, 1'b0);
        chk0.finish_test("rotation and flip");

        set_mode(1'b0, 1'b0, 1'b1);
        drive_random(400, 1'b0);
        chk0.finish_test("4-way filter");

        clear_inputs();
        @(posedge clk);
        en_4way     <= 1'b0;
        autofire_en <= 1'b1;
        key_joy1    <= input_pkg::joy_t'(16);   // Button 1 held
        cnt = 0;
        for (int f = 0; f < 16; f++) begin
            frame();
            cnt = (cnt + 1) % 8;
            @(negedge clk);
            chk0.check_value("button 1", int'(game_joy1[4]),
                             chk0.fire_allowed(cnt) ? 0 : 1);
        end
        @(posedge clk);
        autofire_en <= 1'b0;
        key_joy1    <= '0;
        chk0.finish_test("autofire");

        press_pause();
        expect_pause(1'b1);
        press_pause();
        expect_pause(1'b0);
        @(posedge clk);
        osd_pause <= 1'b1;
        expect_pause(1'b1);
        @(posedge clk);
        osd_pause <= 1'b0;
        expect_pause(1'b0);
        press_pause();
        expect_pause(1'b1);
        press_service();
        expect_pause(1'b0);                     // Stepping one frame
        frame();
        expect_pause(1'b1);
        @(posedge clk);
        lock        <= 1'b1;
        key_joy1    <= '1;
        key_joy2    <= '1;
        key_coin    <= 2'b11;
        key_start   <= 2'b11;
        key_service <= 1'b1;
        expect_pause(1'b0);
        chk0.check_value("locked game_joy1", int'(game_joy1), int'(input_pkg::joy_t'('1)));
        chk0.check_value("locked game_joy2", int'(game_joy2), int'(input_pkg::joy_t'('1)));
        chk0.check_value("locked game_coin", int'(game_coin), 3);
        chk0.check_value("locked game_start", int'(game_start), 3);
        chk0.check_value("locked game_service", int'(game_service), 1);
        @(posedge clk);
        lock        <= 1'b0;
        key_joy1    <= '0;
        key_joy2    <= '0;
        key_coin    <= '0;
        key_start   <= '0;
        key_service <= 1'b0;
        @(posedge clk);
        key_reset <= 1'b1;
        highs = 0;
        repeat (8) begin
            @(negedge clk);
            if (soft_rst) highs++;
        end
        @(posedge clk);
        key_reset <= 1'b0;
        chk0.check_value("soft_rst high cycles", highs, 1);
        chk0.finish_test("pause, step and soft reset");

        drive_random(20, 1'b0);
        drive_random(300, 1'b1);
        chk0.finish_test("paddle");

        ticks(3);
        $display("%0d checks, %0d errors", chk0.n_checks, chk0.n_errors);
        if (chk0.n_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/input_checker.sv
/*
 * Checker for the input conditioner
 * Reference models for merge, filter, rotation, autofire and paddle
 * Continuous comparison of the mapped outputs and the paddle
 */
`default_nettype none

`include "input_macros.svh"

module input_checker (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                map_check,
    input wire logic                en_4way,
    input wire logic                rot_control,
    input wire logic                dip_flip,
    input wire logic                lock,
    input wire input_pkg::raw_joy_t board_joy1,
    input wire input_pkg::raw_joy_t board_joy2,
    input wire input_pkg::joy_t     key_joy1,
    input wire input_pkg::joy_t     key_joy2,
    input wire logic [1:0]          board_coin,
    input wire logic [1:0]          board_start,
    input wire logic [1:0]          key_coin,
    input wire logic [1:0]          key_start,
    input wire logic                key_service,
    input wire logic                key_tilt,
    input wire logic [7:0]          board_paddle,
    input wire logic signed [8:0]   bd_mouse_dx,
    input wire logic                bd_mouse_st,
    input wire input_pkg::joy_t     game_joy1,
    input wire input_pkg::joy_t     game_joy2,
    input wire logic [1:0]          game_coin,
    input wire logic [1:0]          game_start,
    input wire logic                game_service,
    input wire logic                game_tilt,
    input wire logic [7:0]          game_paddle
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int EXP_W = 2 * `INPUT_JOY_W + 6;

    int n_checks = 0;
    int n_errors = 0;
    int test_base = 0;

    input_pkg::dir_t   last1, last2;               // Remembered 4-way directions
    logic [EXP_W-1:0]  pipe0, pipe1;
    logic [1:0]        vld;
    logic [7:0]        pad_pos, pad_exp;
    logic              pad_seen, pad_vld;

    function automatic input_pkg::dir_t filter4(input input_pkg::dir_t d,
        input input_pkg::dir_t last);
        input_pkg::dir_t r;
        r = '0;
        if (d == '0) return r;
        if ($countones(d) == 1) return d;
        if ((d & last) != '0) return last;
        for (int i = 0; i < 4; i++) begin
            if (d[i]) r = input_pkg::dir_t'(1 << i); // Highest set bit wins
        end
        return r;
    endfunction

    function automatic input_pkg::joy_t expect_joy(input input_pkg::raw_joy_t b,
        input input_pkg::joy_t k, input input_pkg::dir_t d, input logic rot,
        input logic flip, input logic lk);
        input_pkg::joy_t w;
        input_pkg::dir_t o;
        w = {b[`INPUT_JOY_W-1:4], d} | k;
        o = w[3:0];
        // Bit order is right, left, down, up
        if (rot && !flip) w[3:0] = {o[0], o[1], o[3], o[2]};
        else if (rot)     w[3:0] = {o[1], o[0], o[2], o[3]};
        if (lk) w = '0;
        return w ^ {`INPUT_JOY_W{`INPUT_ACTIVE_LOW}};
    endfunction

    function automatic logic fire_allowed(input int cnt);
        return cnt > `INPUT_FIRE_ON;
    endfunction

    function automatic logic [7:0] paddle_sum(input logic [7:0] pos,
        input logic signed [8:0] dx);
        int s;
        s = int'(pos) + int'(dx);
        if (s < 0) return 8'd0;
        if (s > 255) return 8'd255;
        return 8'(s);
    endfunction

    task automatic check_value(input string what, input int got, input int exp);
        n_checks++;
        if (got != exp) begin
            n_errors++;
            $display("Fail %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        $display("%s done, %0d errors", name, n_errors - test_base);
        test_base = n_errors;
    endtask

    // Inputs set at a rising edge are stable here
    always @(negedge clk) begin
        input_pkg::dir_t d1, d2;
        logic [1:0]      coin, start;
        logic            lk;
        if (rst) begin
            last1    = '0;
            last2    = '0;
            vld      = '0;
            pad_pos  = '0;
            pad_seen = 1'b0;
            pad_vld  = 1'b0;
        end else begin
            if (vld[1]) begin
                check_value("game_joy1", int'(game_joy1), int'(pipe1[EXP_W-1 -: `INPUT_JOY_W]));
                check_value("game_joy2", int'(game_joy2), int'(pipe1[15:6]));
                check_value("game_coin", int'(game_coin), int'(pipe1[5:4]));
                check_value("game_start", int'(game_start), int'(pipe1[3:2]));
                check_value("game_service", int'(game_service), int'(pipe1[1]));
                check_value("game_tilt", int'(game_tilt), int'(pipe1[0]));
            end
            if (pad_vld) check_value("game_paddle", int'(game_paddle), int'(pad_exp));

            d1 = en_4way ? filter4(board_joy1[3:0], last1) : board_joy1[3:0];
            d2 = en_4way ? filter4(board_joy2[3:0], last2) : board_joy2[3:0];
            if (en_4way && $countones(board_joy1[3:0]) == 1) last1 = board_joy1[3:0];
            if (en_4way && $countones(board_joy2[3:0]) == 1) last2 = board_joy2[3:0];
            lk    = lock;
            coin  = {board_joy2[`INPUT_COIN_BIT], board_joy1[`INPUT_COIN_BIT]}
                    | board_coin | key_coin;
            start = {board_joy2[`INPUT_START_BIT], board_joy1[`INPUT_START_BIT]}
                    | board_start | key_start;
            pipe1 = pipe0;
            vld[1] = vld[0];
            pipe0 = {expect_joy(board_joy1, key_joy1, d1, rot_control, dip_flip, lk),
                     expect_joy(board_joy2, key_joy2, d2, rot_control, dip_flip, lk),
                     lk ? 2'b11 : ~coin, lk ? 2'b11 : ~start,
                     lk ? 1'b1 : ~key_service, ~key_tilt};
            vld[0] = map_check;

            if (bd_mouse_st) begin
                pad_pos  = paddle_sum(pad_seen ? pad_pos : board_paddle, bd_mouse_dx);
                pad_seen = 1'b1;
            end else if (!pad_seen) begin
                pad_pos = board_paddle;
            end
            pad_exp = pad_pos;
            pad_vld = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/input_top.sv
/*
 * Input conditioner top level
 * Stick filters, frame control, joystick mapper and paddle
 */
`default_nettype none

module input_top (
    input  wire logic                rst,
    input  wire logic                clk,
    input  wire logic                vs,
    input  wire logic                en_4way,
    input  wire logic                autofire_en,
    input  wire logic                rot_control,
    input  wire logic                dip_flip,
    input  wire logic                lock,
    input  wire input_pkg::raw_joy_t board_joy1,
    input  wire input_pkg::raw_joy_t board_joy2,
    input  wire logic [1:0]          board_coin,
    input  wire logic [1:0]          board_start,
    input  wire input_pkg::joy_t     key_joy1,
    input  wire input_pkg::joy_t     key_joy2,
    input  wire logic [1:0]          key_coin,
    input  wire logic [1:0]          key_start,
    input  wire logic                key_service,
    input  wire logic                key_tilt,
    input  wire logic                key_pause,
    input  wire logic                osd_pause,
    input  wire logic                key_reset,
    input  wire logic [7:0]          board_paddle,
    input  wire logic signed [8:0]   bd_mouse_dx,
    input  wire logic                bd_mouse_st,
    output input_pkg::joy_t          game_joy1,
    output input_pkg::joy_t          game_joy2,
    output logic [1:0]               game_coin,
    output logic [1:0]               game_start,
    output logic                     game_service,
    output logic                     game_tilt,
    output logic                     game_pause,
    output logic                     soft_rst,
    output logic [7:0]               game_paddle
);

    input_pkg::dir_t dir1, dir2;
    logic            autofire_ok, joy_pause, service_press;

    four_way_filter u_filt1 (
        .rst    (rst),
        .clk    (clk),
        .enable (en_4way),
        .joy8   (board_joy1[3:0]),
        .joy4   (dir1)
    );

    four_way_filter u_filt2 (
        .rst    (rst),
        .clk    (clk),
        .enable (en_4way),
        .joy8   (board_joy2[3:0]),
        .joy4   (dir2)
    );

    frame_ctrl u_frame (
        .rst           (rst),
        .clk           (clk),
        .vs            (vs),
        .autofire_en   (autofire_en),
        .key_pause     (key_pause),
        .osd_pause     (osd_pause),
        .key_reset     (key_reset),
        .lock          (lock),
        .joy_pause     (joy_pause),
        .service_press (service_press),
        .autofire_ok   (autofire_ok),
        .game_pause    (game_pause),
        .soft_rst      (soft_rst)
    );

    joy_mapper u_mapper (
        .rst           (rst),
        .clk           (clk),
        .board_joy1    (board_joy1),
        .board_joy2    (board_joy2),
        .dir1          (dir1),
        .dir2          (dir2),
        .key_joy1      (key_joy1),
        .key_joy2      (key_joy2),
        .board_coin    (board_coin),
        .board_start   (board_start),
        .key_coin      (key_coin),
        .key_start     (key_start),
        .key_service   (key_service),
        .key_tilt      (key_tilt),
        .rot_control   (rot_control),
        .dip_flip      (dip_flip),
        .autofire_ok   (autofire_ok),
        .lock          (lock),
        .game_joy1     (game_joy1),
        .game_joy2     (game_joy2),
        .game_coin     (game_coin),
        .game_start    (game_start),
        .game_service  (game_service),
        .game_tilt     (game_tilt),
        .joy_pause     (joy_pause),
        .service_press (service_press)
    );

    paddle_accum u_paddle (
        .rst       (rst),
        .clk       (clk),
        .hw_paddle (board_paddle),
        .mouse_dx  (bd_mouse_dx),
        .mouse_st  (bd_mouse_st),
        .paddle    (game_paddle)
    );

endmodule

`default_nettype wire

//--- source/paddle_accum.sv
/*
 * Paddle position from mouse movement
 * Board paddle passes until the first mouse report
 */
`default_nettype none

module paddle_accum (
    input  wire logic              rst,
    input  wire logic              clk,
    input  wire logic [7:0]        hw_paddle,
    input  wire logic signed [8:0] mouse_dx,
    input  wire logic              mouse_st,
    output logic [7:0]             paddle
);

    logic              mouse_seen;
    logic signed [9:0] sum;

    // First strobe starts from the current board value
    assign sum = $signed({2'b00, mouse_seen ? paddle : hw_paddle}) + 10'(mouse_dx);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mouse_seen <= 1'b0;
            paddle     <= '0;
        end else if (mouse_st) begin
            mouse_seen <= 1'b1;
            if (sum < 0)        paddle <= 8'd0;   // Clamp at both ends
            else if (sum > 255) paddle <= 8'd255;
            else                paddle <= sum[7:0];
        end else if (!mouse_seen) begin
            paddle <= hw_paddle;
        end
    end

endmodule

`default_nettype wire

//--- source/joy_mapper.sv
/*
 * Joystick, coin and start mapping
 * Input merge stage, then rotation, autofire, polarity and lock
 */
`default_nettype none

`include "input_macros.svh"

module joy_mapper (
    input  wire logic                rst,
    input  wire logic                clk,
    input  wire input_pkg::raw_joy_t board_joy1,
    input  wire input_pkg::raw_joy_t board_joy2,
    input  wire input_pkg::dir_t     dir1,
    input  wire input_pkg::dir_t     dir2,
    input  wire input_pkg::joy_t     key_joy1,
    input  wire input_pkg::joy_t     key_joy2,
    input  wire logic [1:0]          board_coin,
    input  wire logic [1:0]          board_start,
    input  wire logic [1:0]          key_coin,
    input  wire logic [1:0]          key_start,
    input  wire logic                key_service,
    input  wire logic                key_tilt,
    input  wire logic                rot_control,
    input  wire logic                dip_flip,
    input  wire logic                autofire_ok,
    input  wire logic                lock,
    output input_pkg::joy_t          game_joy1,
    output input_pkg::joy_t          game_joy2,
    output logic [1:0]               game_coin,
    output logic [1:0]               game_start,
    output logic                     game_service,
    output logic                     game_tilt,
    output logic                     joy_pause,
    output logic                     service_press
);

    localparam input_pkg::joy_t JOY_IDLE  = {`INPUT_JOY_W{`INPUT_ACTIVE_LOW}};
    localparam logic [1:0]      PAIR_IDLE = {2{`INPUT_ACTIVE_LOW}};

    input_pkg::joy_t in1_r, in2_r;
    logic [1:0]      coin_r, start_r, pause_r;
    logic            service_r, service_l, tilt_r, lock_r;

    // Directions are added later from the registered filter output
    function automatic input_pkg::joy_t map_joy(input input_pkg::joy_t w,
        input input_pkg::dir_t d, input logic rot, input logic flip, input logic fire);
        input_pkg::joy_t r;
        r = w | input_pkg::joy_t'(d);
        r[4] = r[4] & fire;                    // Autofire gates button 1
        if (rot) begin
            r[3:0] = flip ? {r[1], r[0], r[2], r[3]} : {r[0], r[1], r[3], r[2]};
        end
        return r ^ JOY_IDLE;
    endfunction

    assign joy_pause     = |pause_r;
    assign service_press = service_r & ~service_l;

    always_ff @(posedge clk) begin
        in1_r   <= {board_joy1[`INPUT_JOY_W-1:4], 4'b0} | key_joy1;
        in2_r   <= {board_joy2[`INPUT_JOY_W-1:4], 4'b0} | key_joy2;
        coin_r  <= {board_joy2[`INPUT_COIN_BIT], board_joy1[`INPUT_COIN_BIT]}
                   | board_coin | key_coin;
        start_r <= {board_joy2[`INPUT_START_BIT], board_joy1[`INPUT_START_BIT]}
                   | board_start | key_start;
        tilt_r  <= key_tilt;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pause_r   <= '0;
            service_r <= 1'b0;
            service_l <= 1'b0;
            lock_r    <= 1'b0;
        end else begin
            pause_r   <= {board_joy2[`INPUT_PAUSE_BIT], board_joy1[`INPUT_PAUSE_BIT]};
            service_r <= key_service;
            service_l <= service_r;
            lock_r    <= lock;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_joy1    <= JOY_IDLE;
            game_joy2    <= JOY_IDLE;
            game_coin    <= PAIR_IDLE;
            game_start   <= PAIR_IDLE;
            game_service <= `INPUT_ACTIVE_LOW;
            game_tilt    <= `INPUT_ACTIVE_LOW;
        end else begin
            game_tilt <= tilt_r ^ `INPUT_ACTIVE_LOW; // Tilt is never locked
            if (lock_r) begin
                game_joy1    <= JOY_IDLE;
                game_joy2    <= JOY_IDLE;
                game_coin    <= PAIR_IDLE;
                game_start   <= PAIR_IDLE;
                game_service <= `INPUT_ACTIVE_LOW;
            end else begin
                game_joy1    <= map_joy(in1_r, dir1, rot_control, dip_flip, autofire_ok);
                game_joy2    <= map_joy(in2_r, dir2, rot_control, dip_flip, autofire_ok);
                game_coin    <= coin_r ^ PAIR_IDLE;
                game_start   <= start_r ^ PAIR_IDLE;
                game_service <= service_r ^ `INPUT_ACTIVE_LOW;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/frame_ctrl.sv
/*
 * Frame level control
 * Vblank edges, autofire pacing, pause FSM with frame step, soft reset
 */
`default_nettype none

`include "input_macros.svh"

module frame_ctrl (
    input  wire logic rst,
    input  wire logic clk,
    input  wire logic vs,
    input  wire logic autofire_en,
    input  wire logic key_pause,
    input  wire logic osd_pause,
    input  wire logic key_reset,
    input  wire logic lock,
    input  wire logic joy_pause,
    input  wire logic service_press,
    output logic      autofire_ok,
    output logic      game_pause,
    output logic      soft_rst
);

    input_pkg::pause_state_t state, state_nx;
    input_pkg::fire_cnt_t    fire_cnt;

    logic vs_l, vbl_in, vbl_out;
    logic key_pause_s, key_pause_l, joy_pause_s, joy_pause_l;
    logic osd_s, osd_l, reset_l;
    logic toggle, osd_change;

    assign vbl_in     = vs & ~vs_l;            // Vblank start
    assign vbl_out    = ~vs & vs_l;            // Vblank end
    assign toggle     = (key_pause_s & ~key_pause_l) | (joy_pause_s & ~joy_pause_l);
    assign osd_change = osd_s ^ osd_l;
    assign game_pause = (state == input_pkg::PAUSED);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vs_l        <= 1'b0;
            fire_cnt    <= '0;
            autofire_ok <= 1'b1;
        end else begin
            vs_l <= vs;
            if (vbl_in) fire_cnt <= fire_cnt + 1'b1;
            autofire_ok <= !autofire_en || (fire_cnt > `INPUT_FIRE_ON);
        end
    end

    // Pause requests are sampled before edge detection
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_pause_s <= 1'b0;
            key_pause_l <= 1'b0;
            joy_pause_s <= 1'b0;
            joy_pause_l <= 1'b0;
            osd_s       <= 1'b0;
            osd_l       <= 1'b0;
            reset_l     <= 1'b0;
            soft_rst    <= 1'b0;
            state       <= input_pkg::RUNNING;
        end else begin
            key_pause_s <= key_pause;
            key_pause_l <= key_pause_s;
            joy_pause_s <= joy_pause;
            joy_pause_l <= joy_pause_s;
            osd_s       <= osd_pause;
            osd_l       <= osd_s;
            reset_l     <= key_reset;
            soft_rst    <= key_reset & ~reset_l;
            state       <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        if (lock) begin
            state_nx = input_pkg::RUNNING;
        end else if (osd_change) begin
            state_nx = osd_s ? input_pkg::PAUSED : input_pkg::RUNNING;
        end else begin
            case (state)
                input_pkg::RUNNING:  if (toggle) state_nx = input_pkg::PAUSED;
                input_pkg::PAUSED: begin
                    if (toggle)             state_nx = input_pkg::RUNNING;
                    else if (service_press) state_nx = input_pkg::STEPPING;
                end
                input_pkg::STEPPING: if (vbl_out) state_nx = input_pkg::PAUSED;
                default:             state_nx = input_pkg::RUNNING;
            endcase
        end
    end

    a_soft_rst_pulse: assert property (@(posedge clk) disable iff (rst)
        soft_rst |=> !soft_rst);

endmodule

`default_nettype wire

//--- source/four_way_filter.sv
/*
 * 8-way to 4-way stick filter
 * Keeps the last single direction while diagonals are held
 */
`default_nettype none

module four_way_filter (
    input  wire logic            rst,
    input  wire logic            clk,
    input  wire logic            enable,
    input  wire input_pkg::dir_t joy8,
    output input_pkg::dir_t      joy4
);

    input_pkg::dir_t last_dir;

    function automatic input_pkg::dir_t highest_bit(input input_pkg::dir_t d);
        input_pkg::dir_t r;
        r = '0;
        if (d[3])      r = 4'b1000;
        else if (d[2]) r = 4'b0100;
        else if (d[1]) r = 4'b0010;
        else if (d[0]) r = 4'b0001;
        return r;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            joy4     <= '0;
            last_dir <= '0;
        end else if (!enable) begin
            joy4 <= joy8;                      // Straight through, one cycle late
        end else if (joy8 == '0) begin
            joy4 <= '0;
        end else if ($onehot(joy8)) begin
            joy4     <= joy8;
            last_dir <= joy8;
        end else if ((joy8 & last_dir) != '0) begin
            joy4 <= last_dir;                  // Diagonal, hold previous way
        end else begin
            joy4 <= highest_bit(joy8);
        end
    end

    a_single_dir: assert property (@(posedge clk) disable iff (rst)
        enable |=> $onehot0(joy4));

endmodule

`default_nettype wire

//--- source/input_pkg.sv
/*
 * Shared types for the input conditioner
 * Joystick words, direction group, frame counter, pause states
 */
`default_nettype none

`include "input_macros.svh"

package input_pkg;

    // Game word: right, left, down, up, then buttons
    typedef logic [`INPUT_JOY_W-1:0] joy_t;

    typedef logic [15:0] raw_joy_t;            // Board stick, active high
    typedef logic [3:0] dir_t;
    typedef logic [`INPUT_FIRE_W-1:0] fire_cnt_t;

    typedef enum logic [1:0] {
        RUNNING,
        PAUSED,
        STEPPING                               // Runs until the next vblank end
    } pause_state_t;

endpackage

`default_nettype wire

//--- source/input_macros.svh
/*
 * Build constants for the input conditioner
 * Polarity, button count, board word bit positions, autofire timing
 */
`ifndef INPUT_MACROS_SVH
`define INPUT_MACROS_SVH

`define INPUT_ACTIVE_LOW 1'b1                  // Game side wants inverted inputs
`define INPUT_BUTTONS    2
`define INPUT_JOY_W      (8 + `INPUT_BUTTONS)

// Board stick word positions shift with the button count
`define INPUT_START_BIT  (6 + `INPUT_BUTTONS - 2)
`define INPUT_COIN_BIT   (7 + `INPUT_BUTTONS - 2)
`define INPUT_PAUSE_BIT  (8 + `INPUT_BUTTONS - 2)

`define INPUT_FIRE_ON    5                     // Fire allowed above this frame count
`define INPUT_FIRE_W     3
`endif
